//--- Makefile
VERILATOR ?= verilator
TOP       ?= periph_system_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/periph_system_sva.sv
// Assertions on host bus response timing and output reset state, bound into the subsystem top.
`timescale 1ns/100ps

module periph_system_sva #(
  parameter int unsigned GpoWidth = 16,
  parameter int unsigned PwmWidth = 4
) (
  input logic                clk_sys_i,
  input logic                rst_i,
  input logic                bus_req_i,
  input logic                bus_rvalid_o,
  input logic                bus_err_o,
  input logic [GpoWidth-1:0] gp_o,
  input logic [PwmWidth-1:0] pwm_o,
  input logic                timer_irq_o
);

  // Exactly one response, one cycle after each request.
  rvalid_follows_req: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    bus_rvalid_o == $past(bus_req_i))
    else $error("bus_rvalid_o does not follow bus_req_i by one cycle");

  err_only_with_rvalid: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    bus_err_o |-> bus_rvalid_o)
    else $error("bus_err_o raised without bus_rvalid_o");

  // Reset state of every output.
  outputs_idle_in_reset: assert property (@(posedge clk_sys_i)
    $past(rst_i) |-> (!bus_rvalid_o && !bus_err_o && !timer_irq_o &&
                      gp_o == '0 && pwm_o == '0))
    else $error("outputs active right after reset");

endmodule

//--- verification/periph_system_tb.sv
// Testbench for the peripheral subsystem; drives the host bus, models every register, checks responses.
`timescale 1ns/100ps

module periph_system_tb;
  import bus_pkg::*;
  import periph_pkg::*;

  localparam int unsigned GpiWidth = 8;
  localparam int unsigned GpoWidth = 16;
  localparam int unsigned PwmWidth = 4;

  logic                clk_sys_i;
  logic                rst_i;
  logic                bus_req_i;
  logic                bus_we_i;
  bus_addr_t           bus_addr_i;
  bus_be_t             bus_be_i;
  bus_data_t           bus_wdata_i;
  logic                bus_rvalid_o;
  bus_data_t           bus_rdata_o;
  logic                bus_err_o;
  logic [GpiWidth-1:0] gp_i;
  logic [GpoWidth-1:0] gp_o;
  logic [PwmWidth-1:0] pwm_o;
  logic                timer_irq_o;

  // Register model.
  logic [GpoWidth-1:0]   gpo_ref;
  logic [GpiWidth-1:0]   gpi_ref;
  logic [PwmCtrSize-1:0] duty_ref   [PwmWidth];
  logic [PwmCtrSize-1:0] period_ref [PwmWidth];
  logic [63:0]           mtime_ref;
  logic [63:0]           cmp_ref;

  // Outstanding requests, oldest first.
  int          exp_cyc_q [$];
  logic [32:0] exp_val_q [$];

  int        cyc;
  int        errors;
  int        tests_run;
  int        tests_failed;
  bus_data_t last_rdata;

  periph_system #(
    .GpiWidth ( GpiWidth ),
    .GpoWidth ( GpoWidth ),
    .PwmWidth ( PwmWidth )
  ) periph_system_inst (
    .clk_sys_i    (clk_sys_i),
    .rst_i        (rst_i),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_addr_i   (bus_addr_i),
    .bus_be_i     (bus_be_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_err_o    (bus_err_o),
    .gp_i         (gp_i),
    .gp_o         (gp_o),
    .pwm_o        (pwm_o),
    .timer_irq_o  (timer_irq_o)
  );

  bind periph_system periph_system_sva #(
    .GpoWidth ( GpoWidth ),
    .PwmWidth ( PwmWidth )
  ) sva_inst (
    .clk_sys_i    (clk_sys_i),
    .rst_i        (rst_i),
    .bus_req_i    (bus_req_i),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_err_o    (bus_err_o),
    .gp_o         (gp_o),
    .pwm_o        (pwm_o),
    .timer_irq_o  (timer_irq_o)
  );

  initial begin
    clk_sys_i = 1'b0;
    forever #2 clk_sys_i = ~clk_sys_i;
  end

  always @(posedge clk_sys_i) begin
    cyc <= cyc + 1;
  end

  // mtime steps once per cycle out of reset.
  always @(posedge clk_sys_i) begin
    if (rst_i) begin
      mtime_ref <= '0;
    end else begin
      mtime_ref <= mtime_ref + 64'd1;
    end
  end

  //////////////////////////////////////////////////
  // Reference model.
  //////////////////////////////////////////////////

  // Expected {err, rdata} of an access, from the register map.
  function automatic logic [32:0] ref_read(input bus_addr_t addr, input logic we);
    bus_addr_t page;
    reg_addr_t off;
    int        chan;
    bus_data_t data;
    logic      err;
    page = addr & DevAddrMask;
    off  = addr[7:0];
    chan = int'(off[7:2]);
    data = '0;
    err  = 1'b0;
    if (page == GpioBase) begin
      if (off == GpioOutOffset) begin
        data[GpoWidth-1:0] = gpo_ref;
      end else if (off == GpioInOffset) begin
        data[GpiWidth-1:0] = gpi_ref;
      end
    end else if (page == PwmBase) begin
      if (chan < PwmWidth) begin
        data[7:0]  = duty_ref[chan];
        data[15:8] = period_ref[chan];
      end
    end else if (page == TimerBase) begin
      case (off)
        TimerMtimeLo: data = mtime_ref[31:0];
        TimerMtimeHi: data = mtime_ref[63:32];
        TimerCmpLo:   data = cmp_ref[31:0];
        TimerCmpHi:   data = cmp_ref[63:32];
        default:      err = (off > TimerCmpHi);
      endcase
    end else begin
      err = 1'b1;
    end
    // Write answers carry no data.
    if (we) begin
      data = '0;
    end
    return {err, data};
  endfunction

  task automatic model_write(input bus_addr_t addr, input bus_be_t be, input bus_data_t wdata);
    bus_addr_t page;
    reg_addr_t off;
    int        chan;
    page = addr & DevAddrMask;
    off  = addr[7:0];
    chan = int'(off[7:2]);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        if (page == GpioBase && off == GpioOutOffset && b < GpoWidth / 8) begin
          gpo_ref[b*8 +: 8] = wdata[b*8 +: 8];
        end
        if (page == TimerBase && off == TimerCmpLo) begin
          cmp_ref[b*8 +: 8] = wdata[b*8 +: 8];
        end
        if (page == TimerBase && off == TimerCmpHi) begin
          cmp_ref[32 + b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
    if (page == PwmBase && chan < PwmWidth) begin
      if (be[0]) begin
        duty_ref[chan] = wdata[7:0];
      end
      if (be[1]) begin
        period_ref[chan] = wdata[15:8];
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Response checker.
  //////////////////////////////////////////////////

  // Each request is answered at the negedge of the following cycle.
  always @(negedge clk_sys_i) begin
    logic [32:0] exp_val;
    int          exp_cyc;
    if (exp_cyc_q.size() != 0 && cyc == exp_cyc_q[0] + 1) begin
      exp_cyc = exp_cyc_q.pop_front();
      exp_val = exp_val_q.pop_front();
      if (!bus_rvalid_o) begin
        $display("No bus response at %0t for the request of cycle %0d", $time, exp_cyc);
        errors++;
      end else begin
        last_rdata = bus_rdata_o;
        if (bus_rdata_o !== exp_val[31:0]) begin
          $display("ERROR %0t: bus_rdata_o = %h, expected %h", $time, bus_rdata_o,
                   exp_val[31:0]);
          errors++;
        end
        if (bus_err_o !== exp_val[32]) begin
          $display("ERROR %0t: bus_err_o = %b, expected %b", $time, bus_err_o, exp_val[32]);
          errors++;
        end
      end
    end else if (bus_rvalid_o) begin
      $display("Bus response at %0t without an outstanding request", $time);
      errors++;
    end
  end

  //////////////////////////////////////////////////
  // Bus helpers.
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_sys_i);
    #1;
  endtask

  // Drives one request for one cycle; consecutive calls give back-to-back traffic.
  task automatic bus_access(input logic we, input bus_addr_t addr, input bus_be_t be,
                            input bus_data_t wdata);
    exp_val_q.push_back(ref_read(addr, we));
    exp_cyc_q.push_back(cyc);
    if (we) begin
      model_write(addr, be, wdata);
    end
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    bus_req_i   = 1'b1;
    next_cycle();
    bus_req_i   = 1'b0;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (exp_cyc_q.size() != 0 && waited < 10) begin
      next_cycle();
      waited++;
    end
    if (exp_cyc_q.size() != 0) begin
      $display("Timed out at %0t with %0d bus responses missing", $time, exp_cyc_q.size());
      errors++;
      exp_cyc_q.delete();
      exp_val_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, errors - err_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequences.
  //////////////////////////////////////////////////

  task automatic gpio_out_writes();
    for (int i = 0; i < 16; i++) begin
      bus_access(1'b1, GpioBase + 32'(GpioOutOffset), 4'($urandom), $urandom);
      bus_access(1'b0, GpioBase + 32'(GpioOutOffset), 4'hF, '0);
      wait_responses();
      if (gp_o !== gpo_ref) begin
        $display("ERROR %0t: gp_o = %h, expected %h", $time, gp_o, gpo_ref);
        errors++;
      end
    end
  endtask

  task automatic gpio_in_sampling();
    for (int i = 0; i < 8; i++) begin
      gp_i    = GpiWidth'($urandom);
      gpi_ref = gp_i;
      for (int w = 0; w < 3; w++) begin
        next_cycle();
      end
      bus_access(1'b0, GpioBase + 32'(GpioInOffset), 4'hF, '0);
      wait_responses();
    end
  endtask

  task automatic pwm_duty_cycles();
    int cnt [PwmWidth];
    int exp_cnt;
    for (int round = 0; round < 3; round++) begin
      for (int n = 0; n < PwmWidth; n++) begin
        bus_access(1'b1, PwmBase + 32'(4 * n), 4'b0011, {16'h0, 16'($urandom)});
      end
      for (int n = 0; n < PwmWidth; n++) begin
        bus_access(1'b0, PwmBase + 32'(4 * n), 4'hF, '0);
      end
      wait_responses();
      next_cycle();
      next_cycle();
      for (int n = 0; n < PwmWidth; n++) begin
        cnt[n] = 0;
      end
      // One full period of every channel.
      for (int i = 0; i < 256; i++) begin
        for (int n = 0; n < PwmWidth; n++) begin
          if (i <= int'(period_ref[n])) begin
            cnt[n] += int'(pwm_o[n]);
          end
        end
        next_cycle();
      end
      for (int n = 0; n < PwmWidth; n++) begin
        exp_cnt = int'(period_ref[n]) + 1;
        if (int'(duty_ref[n]) < exp_cnt) begin
          exp_cnt = int'(duty_ref[n]);
        end
        if (cnt[n] != exp_cnt) begin
          $display("ERROR %0t: pwm_o[%0d] high cycles = %0d, expected %0d", $time, n,
                   cnt[n], exp_cnt);
          errors++;
        end
      end
    end
  endtask

  task automatic timer_count_and_irq();
    int          t0;
    int          t1;
    int          k;
    int          n_cyc;
    int          j;
    logic        rose;
    bus_data_t   v0;
    logic [63:0] tgt;
    t0 = cyc;
    bus_access(1'b0, TimerBase + 32'(TimerMtimeLo), 4'hF, '0);
    wait_responses();
    v0 = last_rdata;
    k  = 3 + int'($urandom % 20);
    for (int w = 0; w < k; w++) begin
      next_cycle();
    end
    t1 = cyc;
    bus_access(1'b0, TimerBase + 32'(TimerMtimeLo), 4'hF, '0);
    wait_responses();
    if (last_rdata - v0 != bus_data_t'(t1 - t0)) begin
      $display("ERROR %0t: mtime delta = %0d, expected %0d", $time, last_rdata - v0, t1 - t0);
      errors++;
    end
    // High half first, so the low half alone arms the compare.
    bus_access(1'b1, TimerBase + 32'(TimerCmpHi), 4'hF, '0);
    n_cyc = 10 + int'($urandom % 30);
    tgt   = mtime_ref + 64'(n_cyc);
    bus_access(1'b1, TimerBase + 32'(TimerCmpLo), 4'hF, tgt[31:0]);
    j    = 1;
    rose = 1'b0;
    while (!rose && j <= n_cyc + 4) begin
      if (timer_irq_o) begin
        rose = 1'b1;
        if (j <= n_cyc - 2) begin
          $display("timer_irq_o rose %0d cycles after a compare set %0d ahead", j, n_cyc);
          errors++;
        end
      end else begin
        next_cycle();
        j++;
      end
    end
    if (!rose) begin
      $display("timer_irq_o did not rise within %0d cycles", n_cyc + 4);
      errors++;
    end
    bus_access(1'b1, TimerBase + 32'(TimerCmpLo), 4'hF, 32'hFFFF_FFFF);
    bus_access(1'b1, TimerBase + 32'(TimerCmpHi), 4'hF, 32'hFFFF_FFFF);
    j = 0;
    while (timer_irq_o && j < 8) begin
      next_cycle();
      j++;
    end
    if (timer_irq_o) begin
      $display("timer_irq_o still high after mtimecmp was set to all ones");
      errors++;
    end
    wait_responses();
  endtask

  task automatic error_responses();
    bus_access(1'b0, 32'h0000_0000, 4'hF, '0);
    bus_access(1'b1, 32'h8000_3000, 4'hF, $urandom);
    bus_access(1'b0, 32'h9000_2000, 4'hF, '0);
    bus_access(1'b0, TimerBase + 32'h10, 4'hF, '0);
    bus_access(1'b1, TimerBase + 32'hFC, 4'hF, $urandom);
    bus_access(1'b0, GpioBase + 32'(GpioOutOffset), 4'hF, '0);
    bus_access(1'b0, TimerBase + 32'(TimerCmpLo), 4'hF, '0);
    wait_responses();
  endtask

  task automatic back_to_back_traffic(input int count);
    logic      we;
    reg_addr_t off;
    bus_addr_t addr;
    for (int i = 0; i < count; i++) begin
      we = 1'($urandom);
      case ($urandom_range(3, 0))
        0: addr = GpioBase + 32'(($urandom % 3) * 4);
        1: addr = PwmBase + 32'(($urandom % (PwmWidth + 2)) * 4);
        2: begin
          off  = 8'(($urandom % 6) * 4);
          addr = TimerBase + 32'(off);
          // mtime stays free running.
          if (off < TimerCmpLo) begin
            we = 1'b0;
          end
        end
        default: addr = ((($urandom % 2) != 0) ? 32'h8000_3000 : 32'h0) + 32'($urandom % 64);
      endcase
      bus_access(we, addr, 4'($urandom), $urandom);
    end
    wait_responses();
  endtask

  //////////////////////////////////////////////////
  // Main sequence.
  //////////////////////////////////////////////////

  initial begin
    int err_start;
    void'($urandom(32'h2ac5));
    rst_i       = 1'b1;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_be_i    = '0;
    bus_wdata_i = '0;
    gp_i        = '0;
    gpo_ref     = '0;
    gpi_ref     = '0;
    cmp_ref     = TimerCmpReset;
    duty_ref    = '{default: '0};
    period_ref  = '{default: '0};
    cyc          = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < 4; i++) begin
      next_cycle();
    end
    rst_i = 1'b0;
    next_cycle();

    err_start = errors;
    gpio_out_writes();
    report_test("gpio output", err_start);
    err_start = errors;
    gpio_in_sampling();
    report_test("gpio input", err_start);
    err_start = errors;
    pwm_duty_cycles();
    report_test("pwm duty", err_start);
    err_start = errors;
    timer_count_and_irq();
    report_test("timer", err_start);
    err_start = errors;
    error_responses();
    report_test("error responses", err_start);
    err_start = errors;
    back_to_back_traffic(80);
    report_test("back-to-back", err_start);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/bus_decode.sv
// Address decoder between the bus host and the devices; steers requests by page, muxes responses.
`timescale 1ns/100ps

module bus_decode (
  input  logic                clk_sys_i,
  input  logic                rst_i,

  // Host side.
  input  logic                req_i,
  input  logic                we_i,
  input  bus_pkg::bus_addr_t  addr_i,
  input  bus_pkg::bus_be_t    be_i,
  input  bus_pkg::bus_data_t  wdata_i,
  output logic                rvalid_o,
  output bus_pkg::bus_data_t  rdata_o,
  output logic                err_o,

  // Device links.
  reg_bus_if.host             dev_bus [bus_pkg::NrDevices]
);
  import bus_pkg::*;

  bus_device_e sel_dev;
  bus_device_e sel_dev_q;
  logic        miss_q;

  logic        dev_rvalid [NrDevices];
  bus_data_t   dev_rdata  [NrDevices];
  logic        dev_err    [NrDevices];

  //////////////////////////////////////////////////
  // Request path.
  //////////////////////////////////////////////////

  always_comb begin
    sel_dev = NoDevice;
    if ((addr_i & DevAddrMask) == GpioBase) begin
      sel_dev = Gpio;
    end else if ((addr_i & DevAddrMask) == PwmBase) begin
      sel_dev = Pwm;
    end else if ((addr_i & DevAddrMask) == TimerBase) begin
      sel_dev = Timer;
    end
  end

  for (genvar i = 0; i < NrDevices; i++) begin : gen_dev_link
    assign dev_bus[i].req   = req_i && (sel_dev == bus_device_e'(i));
    assign dev_bus[i].we    = we_i;
    assign dev_bus[i].addr  = addr_i[RegAddrWidth-1:0];
    assign dev_bus[i].be    = be_i;
    assign dev_bus[i].wdata = wdata_i;

    assign dev_rvalid[i] = dev_bus[i].rvalid;
    assign dev_rdata[i]  = dev_bus[i].rdata;
    assign dev_err[i]    = dev_bus[i].err;
  end

  //////////////////////////////////////////////////
  // Response path.
  //////////////////////////////////////////////////

  // Target of the request now waiting for its answer.
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      sel_dev_q <= NoDevice;
      miss_q    <= 1'b0;
    end else begin
      sel_dev_q <= sel_dev;
      miss_q    <= req_i && (sel_dev == NoDevice);
    end
  end

  always_comb begin
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    // Unmapped page answers here with an error.
    if (sel_dev_q == NoDevice) begin
      rvalid_o = miss_q;
      err_o    = miss_q;
    end
    for (int i = 0; i < NrDevices; i++) begin
      if (sel_dev_q == bus_device_e'(i)) begin
        rvalid_o = dev_rvalid[i];
        rdata_o  = dev_rdata[i];
        err_o    = dev_err[i];
      end
    end
  end

endmodule

//--- verilog/bus_pkg.sv
// Bus widths, device list and address map shared by the decoder, the devices and the top level.
package bus_pkg;

  //////////////////////////////////////////////////
  // Bus widths.
  //////////////////////////////////////////////////

  parameter int unsigned BusAddrWidth  = 32;
  parameter int unsigned BusDataWidth  = 32;
  parameter int unsigned BusByteEnable = 4;
  parameter int unsigned RegAddrWidth  = 8;

  typedef logic [BusAddrWidth-1:0]  bus_addr_t;
  typedef logic [BusDataWidth-1:0]  bus_data_t;
  typedef logic [BusByteEnable-1:0] bus_be_t;
  typedef logic [RegAddrWidth-1:0]  reg_addr_t;

  //////////////////////////////////////////////////
  // Devices and address map.
  //////////////////////////////////////////////////

  // NoDevice marks an address outside every page.
  typedef enum logic [1:0] {
    Gpio,
    Pwm,
    Timer,
    NoDevice
  } bus_device_e;

  parameter int NrDevices = 3;

  parameter bus_addr_t GpioBase  = 32'h8000_0000;
  parameter bus_addr_t PwmBase   = 32'h8000_1000;
  parameter bus_addr_t TimerBase = 32'h8000_2000;

  // One 4 KiB page per device.
  parameter bus_addr_t DevAddrMask = 32'hFFFF_F000;

endpackage

//--- verilog/gpio.sv
// GPIO device with a byte-writable output register and synchronised, readable inputs.
`timescale 1ns/100ps

module gpio #(
  parameter int unsigned GpiWidth = 8,
  parameter int unsigned GpoWidth = 16
) (
  input  logic                clk_sys_i,
  input  logic                rst_i,

  reg_bus_if.device           bus,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o
);
  import bus_pkg::*;
  import periph_pkg::*;

  logic [GpiWidth-1:0] gp_sync1;
  logic [GpiWidth-1:0] gp_sync2;
  bus_data_t           rd_val;
  logic                rvalid_q;
  bus_data_t           rdata_q;

  // Two-flop synchroniser for the input pins.
  always_ff @(posedge clk_sys_i) begin
    gp_sync1 <= gp_i;
    gp_sync2 <= gp_sync1;
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      gp_o <= '0;
    end else if (bus.req && bus.we && (bus.addr == GpioOutOffset)) begin
      for (int i = 0; i < GpoWidth; i++) begin
        if (bus.be[i/8]) begin
          gp_o[i] <= bus.wdata[i];
        end
      end
    end
  end

  // Reads only; writes answer with zero.
  always_comb begin
    rd_val = '0;
    if (!bus.we) begin
      case (bus.addr)
        GpioOutOffset: rd_val[GpoWidth-1:0] = gp_o;
        GpioInOffset:  rd_val[GpiWidth-1:0] = gp_sync2;
        default:       rd_val = '0;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    rdata_q <= rd_val;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

//--- verilog/periph_pkg.sv
// Register offsets and reset values of the peripheral devices, used by the devices and the testbench.
package periph_pkg;

  //////////////////////////////////////////////////
  // GPIO registers.
  //////////////////////////////////////////////////

  parameter bus_pkg::reg_addr_t GpioOutOffset = 8'h00;
  parameter bus_pkg::reg_addr_t GpioInOffset  = 8'h04;

  //////////////////////////////////////////////////
  // PWM channels.
  //////////////////////////////////////////////////

  // Width of duty, period and channel counter.
  parameter int unsigned PwmCtrSize = 8;

  //////////////////////////////////////////////////
  // Machine timer.
  //////////////////////////////////////////////////

  parameter int unsigned TimerWidth = 64;

  parameter bus_pkg::reg_addr_t TimerMtimeLo = 8'h00;
  parameter bus_pkg::reg_addr_t TimerMtimeHi = 8'h04;
  parameter bus_pkg::reg_addr_t TimerCmpLo   = 8'h08;
  parameter bus_pkg::reg_addr_t TimerCmpHi   = 8'h0C;

  // Compare at all ones keeps the interrupt quiet out of reset.
  parameter logic [TimerWidth-1:0] TimerMtimeReset = '0;
  parameter logic [TimerWidth-1:0] TimerCmpReset   = '1;

endpackage

//--- verilog/periph_system.sv
// Peripheral subsystem top level; the host bus pins reach GPIO, PWM and timer through the decoder.
`timescale 1ns/100ps

module periph_system #(
  parameter int unsigned GpiWidth = 8,
  parameter int unsigned GpoWidth = 16,
  parameter int unsigned PwmWidth = 4
) (
  input  logic                clk_sys_i,
  input  logic                rst_i,

  // Host bus.
  input  logic                bus_req_i,
  input  logic                bus_we_i,
  input  bus_pkg::bus_addr_t  bus_addr_i,
  input  bus_pkg::bus_be_t    bus_be_i,
  input  bus_pkg::bus_data_t  bus_wdata_i,
  output logic                bus_rvalid_o,
  output bus_pkg::bus_data_t  bus_rdata_o,
  output logic                bus_err_o,

  // Pins.
  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o,
  output logic [PwmWidth-1:0] pwm_o,
  output logic                timer_irq_o
);
  import bus_pkg::*;

  // One link per device.
  reg_bus_if dev_bus [NrDevices] ();

  bus_decode u_bus_decode (
    .clk_sys_i (clk_sys_i),
    .rst_i     (rst_i),
    .req_i     (bus_req_i),
    .we_i      (bus_we_i),
    .addr_i    (bus_addr_i),
    .be_i      (bus_be_i),
    .wdata_i   (bus_wdata_i),
    .rvalid_o  (bus_rvalid_o),
    .rdata_o   (bus_rdata_o),
    .err_o     (bus_err_o),
    .dev_bus   (dev_bus)
  );

  gpio #(
    .GpiWidth ( GpiWidth ),
    .GpoWidth ( GpoWidth )
  ) u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_i     (rst_i),
    .bus       (dev_bus[Gpio]),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  pwm #(
    .PwmWidth ( PwmWidth )
  ) u_pwm (
    .clk_sys_i (clk_sys_i),
    .rst_i     (rst_i),
    .bus       (dev_bus[Pwm]),
    .pwm_o     (pwm_o)
  );

  timer u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_i       (rst_i),
    .bus         (dev_bus[Timer]),
    .timer_irq_o (timer_irq_o)
  );

endmodule

//--- verilog/pwm.sv
// Bank of PWM channels, each with a duty and period register and a free-running counter.
`timescale 1ns/100ps

module pwm #(
  parameter int unsigned PwmWidth = 4
) (
  input  logic                clk_sys_i,
  input  logic                rst_i,

  reg_bus_if.device           bus,

  output logic [PwmWidth-1:0] pwm_o
);
  import bus_pkg::*;
  import periph_pkg::*;

  logic [PwmCtrSize-1:0]   duty_q   [PwmWidth];
  logic [PwmCtrSize-1:0]   period_q [PwmWidth];
  logic [PwmCtrSize-1:0]   ctr_q    [PwmWidth];
  logic [RegAddrWidth-3:0] chan_idx;
  bus_data_t               rd_val;
  logic                    rvalid_q;
  bus_data_t               rdata_q;

  // One word per channel.
  assign chan_idx = bus.addr[RegAddrWidth-1:2];

  //////////////////////////////////////////////////
  // Channel registers.
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      duty_q   <= '{default: '0};
      period_q <= '{default: '0};
    end else if (bus.req && bus.we) begin
      for (int n = 0; n < PwmWidth; n++) begin
        if (chan_idx == (RegAddrWidth-2)'(n)) begin
          if (bus.be[0]) begin
            duty_q[n] <= bus.wdata[0 +: PwmCtrSize];
          end
          if (bus.be[1]) begin
            period_q[n] <= bus.wdata[8 +: PwmCtrSize];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Counters and outputs.
  //////////////////////////////////////////////////

  // Counter wraps after reaching period; output follows one cycle later.
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      ctr_q <= '{default: '0};
      pwm_o <= '0;
    end else begin
      for (int n = 0; n < PwmWidth; n++) begin
        ctr_q[n] <= (ctr_q[n] >= period_q[n]) ? '0 : ctr_q[n] + 1'b1;
        pwm_o[n] <= (ctr_q[n] < duty_q[n]);
      end
    end
  end

  always_comb begin
    rd_val = '0;
    if (!bus.we) begin
      for (int n = 0; n < PwmWidth; n++) begin
        if (chan_idx == (RegAddrWidth-2)'(n)) begin
          rd_val[0 +: PwmCtrSize] = duty_q[n];
          rd_val[8 +: PwmCtrSize] = period_q[n];
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    rdata_q <= rd_val;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

//--- verilog/reg_bus_if.sv
// Register bus link from the address decoder to one device, with host and device views.
`timescale 1ns/100ps

interface reg_bus_if;
  import bus_pkg::*;

  // Request side.
  logic      req;
  logic      we;
  reg_addr_t addr;
  bus_be_t   be;
  bus_data_t wdata;

  // Response side, one cycle after req.
  logic      rvalid;
  bus_data_t rdata;
  logic      err;

  modport host (
    output req, we, addr, be, wdata,
    input  rvalid, rdata, err
  );

  modport device (
    input  req, we, addr, be, wdata,
    output rvalid, rdata, err
  );

endinterface

//--- verilog/timer.sv
// Machine timer with a 64-bit counter, a compare register and a level interrupt.
`timescale 1ns/100ps

module timer (
  input  logic      clk_sys_i,
  input  logic      rst_i,

  reg_bus_if.device bus,

  output logic      timer_irq_o
);
  import bus_pkg::*;
  import periph_pkg::*;

  logic [TimerWidth-1:0] mtime_q;
  logic [TimerWidth-1:0] mtimecmp_q;
  logic                  addr_bad;
  logic                  wr_en;
  bus_data_t             rd_val;
  logic                  rvalid_q;
  logic                  err_q;
  bus_data_t             rdata_q;

  // Merge write data into a word under byte enables.
  function automatic bus_data_t apply_be(bus_data_t old_val, bus_data_t new_val, bus_be_t be);
    bus_data_t merged;
    merged = old_val;
    for (int b = 0; b < BusByteEnable; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  assign addr_bad = (bus.addr > TimerCmpHi);
  assign wr_en    = bus.req && bus.we && !addr_bad;

  //////////////////////////////////////////////////
  // Counter and compare.
  //////////////////////////////////////////////////

  // A written half replaces the running count for that cycle.
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      mtime_q    <= TimerMtimeReset;
      mtimecmp_q <= TimerCmpReset;
    end else begin
      mtime_q <= mtime_q + 1'b1;
      if (wr_en) begin
        case (bus.addr)
          TimerMtimeLo: mtime_q[31:0]     <= apply_be(mtime_q[31:0], bus.wdata, bus.be);
          TimerMtimeHi: mtime_q[63:32]    <= apply_be(mtime_q[63:32], bus.wdata, bus.be);
          TimerCmpLo:   mtimecmp_q[31:0]  <= apply_be(mtimecmp_q[31:0], bus.wdata, bus.be);
          TimerCmpHi:   mtimecmp_q[63:32] <= apply_be(mtimecmp_q[63:32], bus.wdata, bus.be);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  //////////////////////////////////////////////////
  // Bus response.
  //////////////////////////////////////////////////

  always_comb begin
    rd_val = '0;
    if (!bus.we) begin
      case (bus.addr)
        TimerMtimeLo: rd_val = mtime_q[31:0];
        TimerMtimeHi: rd_val = mtime_q[63:32];
        TimerCmpLo:   rd_val = mtimecmp_q[31:0];
        TimerCmpHi:   rd_val = mtimecmp_q[63:32];
        default:      rd_val = '0;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req && addr_bad;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    rdata_q <= rd_val;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;

endmodule

//--- vlog.f
verilog/bus_pkg.sv
verilog/periph_pkg.sv
verilog/reg_bus_if.sv
verilog/bus_decode.sv
verilog/gpio.sv
verilog/pwm.sv
verilog/timer.sv
verilog/periph_system.sv
verification/periph_system_sva.sv
verification/periph_system_tb.sv
